// ==== design/vision_pkg.sv ====
// vision_pkg: video widths, pixel structs, colour matrix coefficients, hue and class thresholds
package vision_pkg;

	// ------------------------------
	// basic widths
	// ------------------------------

	// one decoder byte, also one colour channel
	typedef logic [7:0] pixel_byte_t;

	// colour matrix product or sum, signed, Q2.8 coefficient times 4x byte
	typedef logic signed [20:0] product_t;

	// hue on the 240-step circle, 0 to 239
	typedef logic [7:0] hue_t;

	// packed red/orange/yellow/green/blue/black flags
	typedef logic [15:0] class_word_t;

	// byte order of the 4:2:2 stream
	typedef enum logic [1:0] {
		phase_cb = 2'd0,
		phase_y1 = 2'd1,
		phase_cr = 2'd2,
		phase_y2 = 2'd3
	} byte_phase_t;

	// ------------------------------
	// pixel formats between stages
	// ------------------------------

	typedef struct packed {
		pixel_byte_t y;
		pixel_byte_t cb;
		pixel_byte_t cr;
	} ycc_pixel_t;

	typedef struct packed {
		pixel_byte_t r;
		pixel_byte_t g;
		pixel_byte_t b;
	} rgb_pixel_t;

	typedef struct packed {
		hue_t        h;
		pixel_byte_t s;
		pixel_byte_t v;
	} hsv_pixel_t;

	// ------------------------------
	// YCbCr to RGB coefficients
	// ------------------------------

	// Q2.8, 1.164 / 1.596 / 0.813 / 0.392 / 2.017
	localparam product_t coef_y    = 21'sd298;
	localparam product_t coef_cr_r = 21'sd408;
	localparam product_t coef_cr_g = 21'sd208;
	localparam product_t coef_cb_g = 21'sd100;
	localparam product_t coef_cb_b = 21'sd516;

	// black level 16 and chroma zero 128, both scaled by four
	localparam product_t luma_offset   = 21'sd64;
	localparam product_t chroma_offset = 21'sd512;

	// ------------------------------
	// hue scale and class thresholds
	// ------------------------------

	localparam hue_t hue_span   = 8'd240;
	localparam hue_t hue_sector = 8'd40;
	localparam hue_t hue_base_g = 8'd80;
	localparam hue_t hue_base_b = 8'd160;

	localparam pixel_byte_t v_black_limit  = 8'd32;
	localparam pixel_byte_t s_chroma_limit = 8'd64;
	localparam hue_t        hue_window     = 8'd15;

	// window centres on the 240 scale
	localparam hue_t hue_red    = 8'd230;
	localparam hue_t hue_green  = 8'd90;
	localparam hue_t hue_blue   = 8'd144;
	localparam hue_t hue_yellow = 8'd36;
	localparam hue_t hue_orange = 8'd15;

endpackage

// ==== design/ycc_decode.sv ====
// ycc_decode: byte phase counter and Cb/Y/Cr capture forming two YCbCr pixels per group
`timescale 1ns/10ps

module ycc_decode (
	input  logic                    clk_llc,
	input  logic                    resetx,
	input  logic                    sample_active,
	input  vision_pkg::pixel_byte_t video_byte,
	output logic                    ycc_valid,
	output vision_pkg::ycc_pixel_t  ycc
);

	import vision_pkg::*;

	byte_phase_t phase;

	// chroma and first luma of the current group
	pixel_byte_t cb_q;
	pixel_byte_t y1_q;
	pixel_byte_t cr_q;

	// ------------------------------
	// phase counter
	// ------------------------------

	// Cb, Y1, Cr, Y2 then wrap, restart at Cb when the line write drops
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			phase <= phase_cb;
		else if (!sample_active)
			phase <= phase_cb;
		else
			phase <= byte_phase_t'(phase + 2'd1);
	end

	// ------------------------------
	// byte capture
	// ------------------------------

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			cb_q <= '0;
			y1_q <= '0;
			cr_q <= '0;
		end
		else if (sample_active)
		begin
			case (phase)
				phase_cb: cb_q <= video_byte;
				phase_y1: y1_q <= video_byte;
				phase_cr: cr_q <= video_byte;
				// Y2 goes straight into the output pixel
				default:  ;
			endcase
		end
	end

	// ------------------------------
	// pixel output
	// ------------------------------

	// first pixel completes on Cr, second on Y2, same chroma pair
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			ycc_valid <= 1'b0;
			ycc       <= '0;
		end
		else
		begin
			ycc_valid <= sample_active && ((phase == phase_cr) || (phase == phase_y2));
			if (sample_active && (phase == phase_cr))
				ycc <= '{y: y1_q, cb: cb_q, cr: video_byte};
			else if (sample_active && (phase == phase_y2))
				ycc <= '{y: video_byte, cb: cb_q, cr: cr_q};
		end
	end

endmodule

// ==== design/rgb_execute.sv ====
// rgb_execute: YCbCr to RGB888 matrix products, channel sums and saturation
`timescale 1ns/10ps

module rgb_execute (
	input  logic                   clk_llc,
	input  logic                   resetx,
	input  logic                   ycc_valid,
	input  vision_pkg::ycc_pixel_t ycc,
	output logic                   rgb_valid,
	output vision_pkg::rgb_pixel_t rgb
);

	import vision_pkg::*;

	// the five matrix terms of one pixel
	typedef struct packed {
		product_t x;
		product_t a;
		product_t b1;
		product_t b2;
		product_t c;
	} matrix_terms_t;

	product_t      y_term;
	product_t      cb_term;
	product_t      cr_term;
	matrix_terms_t terms_q;
	logic          valid_s1;
	product_t      r_sum;
	product_t      g_sum;
	product_t      b_sum;

	// byte times four as a signed value
	function automatic product_t scale4(input pixel_byte_t value);
		return $signed({11'd0, value, 2'b00});
	endfunction

	// divide by 1024, clip to 0..255
	function automatic pixel_byte_t clamp_channel(input product_t sum);
		product_t scaled;
		scaled = sum >>> 10;
		if (scaled[20])
			return 8'd0;
		else if (|scaled[19:8])
			return 8'd255;
		else
			return scaled[7:0];
	endfunction

	// ------------------------------
	// stage 1, products
	// ------------------------------

	assign y_term  = scale4(ycc.y)  - luma_offset;
	assign cb_term = scale4(ycc.cb) - chroma_offset;
	assign cr_term = scale4(ycc.cr) - chroma_offset;

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			valid_s1 <= 1'b0;
			terms_q  <= '0;
		end
		else
		begin
			valid_s1   <= ycc_valid;
			terms_q.x  <= coef_y    * y_term;
			terms_q.a  <= coef_cr_r * cr_term;
			terms_q.b1 <= coef_cr_g * cr_term;
			terms_q.b2 <= coef_cb_g * cb_term;
			terms_q.c  <= coef_cb_b * cb_term;
		end
	end

	// ------------------------------
	// stage 2, sums and clamp
	// ------------------------------

	// worst case sums stay well inside 21 bits
	assign r_sum = terms_q.x + terms_q.a;
	assign g_sum = terms_q.x - terms_q.b1 - terms_q.b2;
	assign b_sum = terms_q.x + terms_q.c;

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			rgb_valid <= 1'b0;
			rgb       <= '0;
		end
		else
		begin
			rgb_valid <= valid_s1;
			rgb.r     <= clamp_channel(r_sum);
			rgb.g     <= clamp_channel(g_sum);
			rgb.b     <= clamp_channel(b_sum);
		end
	end

endmodule

// ==== design/hsv_execute.sv ====
// RGB888 to HSV pipeline with max/min, delta/saturation and hue stages
`timescale 1ns/10ps

module hsv_execute (
	input  logic                   clk_llc,
	input  logic                   resetx,
	input  logic                   rgb_valid,
	input  vision_pkg::rgb_pixel_t rgb,
	output logic                   hsv_valid,
	output vision_pkg::hsv_pixel_t hsv
);

	import vision_pkg::*;

	// stage 1
	logic        valid_s1;
	pixel_byte_t max_q;
	pixel_byte_t min_q;
	rgb_pixel_t  rgb_q;
	pixel_byte_t max_next;
	pixel_byte_t min_next;

	// stage 2
	logic              valid_s2;
	pixel_byte_t       delta_q;
	pixel_byte_t       s_q;
	pixel_byte_t       v_q;
	hue_t              base_q;
	logic signed [8:0] diff_q;
	pixel_byte_t       delta_next;
	logic [15:0]       s_wide;
	hue_t              base_next;
	logic signed [8:0] diff_next;

	// stage 3
	logic signed [15:0] hue_calc;
	logic [15:0]        hue_wrapped;
	logic [15:0]        delta_div;

	// ------------------------------
	// max and min stage
	// ------------------------------

	always_comb
	begin
		max_next = (rgb.r > rgb.g) ? rgb.r : rgb.g;
		if (rgb.b > max_next)
			max_next = rgb.b;
		min_next = (rgb.r < rgb.g) ? rgb.r : rgb.g;
		if (rgb.b < min_next)
			min_next = rgb.b;
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			valid_s1 <= 1'b0;
			max_q    <= '0;
			min_q    <= '0;
			rgb_q    <= '0;
		end
		else
		begin
			valid_s1 <= rgb_valid;
			max_q    <= max_next;
			min_q    <= min_next;
			rgb_q    <= rgb;
		end
	end

	// ------------------------------
	// delta, saturation and sector stage
	// ------------------------------

	assign delta_next = max_q - min_q;

	// delta*255 fits in 16 bits and the quotient stays within a byte
	assign s_wide = (max_q == 8'd0) ? 16'd0 :
		({8'd0, delta_next} * 16'd255) / {8'd0, max_q};

	// max channel picked in r, g, b order on ties
	always_comb
	begin
		if (max_q == rgb_q.r)
		begin
			base_next = 8'd0;
			diff_next = $signed({1'b0, rgb_q.g}) - $signed({1'b0, rgb_q.b});
		end
		else if (max_q == rgb_q.g)
		begin
			base_next = hue_base_g;
			diff_next = $signed({1'b0, rgb_q.b}) - $signed({1'b0, rgb_q.r});
		end
		else
		begin
			base_next = hue_base_b;
			diff_next = $signed({1'b0, rgb_q.r}) - $signed({1'b0, rgb_q.g});
		end
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			valid_s2 <= 1'b0;
			delta_q  <= '0;
			s_q      <= '0;
			v_q      <= '0;
			base_q   <= '0;
			diff_q   <= '0;
		end
		else
		begin
			valid_s2 <= valid_s1;
			delta_q  <= delta_next;
			s_q      <= s_wide[7:0];
			v_q      <= max_q;
			base_q   <= base_next;
			diff_q   <= diff_next;
		end
	end

	// ------------------------------
	// hue stage
	// ------------------------------

	// grey has diff 0 and base 0 and a divisor of 1 then keeps the hue at 0
	assign delta_div = (delta_q == 8'd0) ? 16'd1 : {8'd0, delta_q};

	// signed divide truncates toward zero
	// |diff| <= delta keeps the result within one sector
	assign hue_calc = $signed({8'd0, base_q}) +
		(diff_q * $signed({8'd0, hue_sector})) / $signed(delta_div);

	// negative red side wraps to the top of the circle
	assign hue_wrapped = hue_calc[15] ? (hue_calc + {8'd0, hue_span}) : hue_calc;

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			hsv_valid <= 1'b0;
			hsv       <= '0;
		end
		else
		begin
			hsv_valid <= valid_s2;
			hsv.h     <= hue_wrapped[7:0];
			hsv.s     <= s_q;
			hsv.v     <= v_q;
		end
	end

endmodule

// ==== design/color_result.sv ====
// color_result: black and chroma tests, hue windows, 16-bit class word packing
`timescale 1ns/10ps

module color_result (
	input  logic                    clk_llc,
	input  logic                    resetx,
	input  logic                    hsv_valid,
	input  vision_pkg::hsv_pixel_t  hsv,
	output logic                    class_valid,
	output vision_pkg::class_word_t class_word
);

	import vision_pkg::*;

	// one flag per colour class
	typedef struct packed {
		logic red;
		logic orange;
		logic yellow;
		logic green;
		logic blue;
		logic black;
	} color_flags_t;

	color_flags_t flags;
	logic         chroma;

	// combined groups of the class word
	logic roy;
	logic roy_bk;
	logic gy;
	logic gyo;
	logic gyo_bk;
	logic b_bk;

	// strict window around a centre, no wrap
	function automatic logic in_window(input hue_t h, input hue_t centre);
		return (h > (centre - hue_window)) && (h < (centre + hue_window));
	endfunction

	// ------------------------------
	// classification
	// ------------------------------

	assign flags.black = (hsv.v < v_black_limit);
	assign chroma      = !flags.black && (hsv.s > s_chroma_limit);

	// red straddles 0, upper edge 230+15-240 = 5
	assign flags.red    = chroma && ((hsv.h > (hue_red - hue_window)) ||
		(hsv.h < (hue_red + hue_window - hue_span)));
	// orange lower edge is 0, so h = 0 stays out
	assign flags.orange = chroma && in_window(hsv.h, hue_orange);
	assign flags.yellow = chroma && in_window(hsv.h, hue_yellow);
	assign flags.green  = chroma && in_window(hsv.h, hue_green);
	assign flags.blue   = chroma && in_window(hsv.h, hue_blue);

	assign roy    = flags.red || flags.orange || flags.yellow;
	assign roy_bk = roy || flags.black;
	assign gy     = flags.green || flags.yellow;
	assign gyo    = gy || flags.orange;
	assign gyo_bk = gyo || flags.black;
	assign b_bk   = flags.blue || flags.black;

	// ------------------------------
	// class word register
	// ------------------------------

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			class_valid <= 1'b0;
			class_word  <= '0;
		end
		else
		begin
			class_valid <= hsv_valid;
			class_word  <= {roy, roy_bk, flags.red, flags.orange, flags.yellow,
				gy, gyo_bk, gyo, flags.green, flags.green, flags.green,
				flags.blue, b_bk, flags.blue, flags.blue, flags.black};
		end
	end

endmodule

// ==== design/color_classifier.sv ====
// color_classifier: top level chaining decode, RGB, HSV and class stages
`timescale 1ns/10ps

module color_classifier (
	input  logic                    clk_llc,
	input  logic                    resetx,
	input  logic                    sample_active,
	input  vision_pkg::pixel_byte_t video_byte,
	output logic                    class_valid,
	output vision_pkg::class_word_t class_word
);

	import vision_pkg::*;

	// stage links, strobe travels with its pixel
	logic       ycc_valid;
	ycc_pixel_t ycc;
	logic       rgb_valid;
	rgb_pixel_t rgb;
	logic       hsv_valid;
	hsv_pixel_t hsv;

	// 1 cycle, byte stream to YCbCr
	ycc_decode ycc_decode_inst (
		.clk_llc       (clk_llc),
		.resetx        (resetx),
		.sample_active (sample_active),
		.video_byte    (video_byte),
		.ycc_valid     (ycc_valid),
		.ycc           (ycc)
	);

	// 2 cycles
	rgb_execute rgb_execute_inst (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.ycc_valid (ycc_valid),
		.ycc       (ycc),
		.rgb_valid (rgb_valid),
		.rgb       (rgb)
	);

	// 3 cycles
	hsv_execute hsv_execute_inst (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.rgb_valid (rgb_valid),
		.rgb       (rgb),
		.hsv_valid (hsv_valid),
		.hsv       (hsv)
	);

	// 1 cycle
	color_result color_result_inst (
		.clk_llc     (clk_llc),
		.resetx      (resetx),
		.hsv_valid   (hsv_valid),
		.hsv         (hsv),
		.class_valid (class_valid),
		.class_word  (class_word)
	);

endmodule

// ==== tests/color_model.svh ====
// pixel model: YCbCr to RGB888, RGB888 to HSV on the 240 scale, class word packing
`ifndef COLOR_MODEL_SVH
`define COLOR_MODEL_SVH

// ------------------------------
// colour matrix
// ------------------------------

// divide by 1024 rounding down, then clip to one byte
function automatic pixel_byte_t saturate_channel(input int sum);
	int q;
	q = sum >>> 10;
	if (q < 0)
		return 8'd0;
	else if (q > 255)
		return 8'd255;
	else
		return q[7:0];
endfunction

// Q2.8 coefficients on the byte times four
function automatic rgb_pixel_t ycc_to_rgb(input pixel_byte_t y, input pixel_byte_t cb,
	input pixel_byte_t cr);
	int yi;
	int cbi;
	int cri;
	int x;
	rgb_pixel_t p;
	yi  = y;
	cbi = cb;
	cri = cr;
	x   = 298 * (4 * yi - 64);
	p.r = saturate_channel(x + 408 * (4 * cri - 512));
	p.g = saturate_channel(x - 208 * (4 * cri - 512) - 100 * (4 * cbi - 512));
	p.b = saturate_channel(x + 516 * (4 * cbi - 512));
	return p;
endfunction

// ------------------------------
// hsv on the 240 step circle
// ------------------------------

function automatic hsv_pixel_t rgb_to_hsv(input rgb_pixel_t c);
	int r;
	int g;
	int b;
	int mx;
	int mn;
	int delta;
	int diff;
	int base;
	int h;
	int s;
	hsv_pixel_t p;
	r  = c.r;
	g  = c.g;
	b  = c.b;
	mx = (r > g) ? r : g;
	mx = (b > mx) ? b : mx;
	mn = (r < g) ? r : g;
	mn = (b < mn) ? b : mn;
	delta = mx - mn;
	s = (mx == 0) ? 0 : (delta * 255) / mx;
	// ties go to r first, then g
	if (mx == r)
	begin
		base = 0;
		diff = g - b;
	end
	else if (mx == g)
	begin
		base = 80;
		diff = b - r;
	end
	else
	begin
		base = 160;
		diff = r - g;
	end
	if (delta == 0)
		h = 0;
	else
	begin
		// int division truncates toward zero
		h = base + (40 * diff) / delta;
		if (h < 0)
			h = h + 240;
	end
	p.h = h[7:0];
	p.s = s[7:0];
	p.v = mx[7:0];
	return p;
endfunction

// ------------------------------
// class word
// ------------------------------

function automatic class_word_t classify_hsv(input hsv_pixel_t p);
	int h;
	logic black;
	logic chroma;
	logic red;
	logic orange;
	logic yellow;
	logic green;
	logic blue;
	class_word_t w;
	h      = p.h;
	black  = (p.v < 8'd32);
	chroma = !black && (p.s > 8'd64);
	// red wraps through zero, 215 < h or h < 5
	red    = chroma && ((h > 215) || (h < 5));
	orange = chroma && (h > 0) && (h < 30);
	yellow = chroma && (h > 21) && (h < 51);
	green  = chroma && (h > 75) && (h < 105);
	blue   = chroma && (h > 129) && (h < 159);
	w[15]  = red | orange | yellow;
	w[14]  = red | orange | yellow | black;
	w[13]  = red;
	w[12]  = orange;
	w[11]  = yellow;
	w[10]  = green | yellow;
	w[9]   = green | yellow | orange | black;
	w[8]   = green | yellow | orange;
	w[7:5] = {3{green}};
	w[4]   = blue;
	w[3]   = blue | black;
	w[2:1] = {2{blue}};
	w[0]   = black;
	return w;
endfunction

// whole chain for one pixel
function automatic class_word_t expected_word(input pixel_byte_t y, input pixel_byte_t cb,
	input pixel_byte_t cr);
	return classify_hsv(rgb_to_hsv(ycc_to_rgb(y, cb, cr)));
endfunction

`endif

// ==== tests/color_classifier_tb.sv ====
// color_classifier_tb: clock, reset, byte stimulus, pixel model queue, checker, watchdog
`timescale 1ns/10ps

module color_classifier_tb;

	import vision_pkg::*;

	`include "color_model.svh"

	// one pixel still in the pipeline
	typedef struct packed {
		class_word_t word;
		logic [31:0] cycle;
	} expected_t;

	localparam int clk_period    = 100;
	localparam int reset_cycles  = 16;
	localparam int random_bytes  = 4000;
	localparam int toggled_bytes = 2000;
	localparam int extreme_count = 5;
	localparam int sweep_steps   = 32;
	localparam int gap_cycles    = 2;
	localparam int drain_cycles  = 20;
	localparam int pipe_latency  = 7;
	localparam int total_cycles  = reset_cycles + random_bytes + toggled_bytes
		+ extreme_count * extreme_count * 4 + sweep_steps * sweep_steps * 4
		+ 4 * gap_cycles + drain_cycles;

	logic        clk_llc;
	logic        resetx;
	logic        sample_active;
	pixel_byte_t video_byte;
	logic        class_valid;
	class_word_t class_word;

	integer      seed;
	int          cyc;
	expected_t   expected_q[$];
	expected_t   head;

	// model side of the byte phase
	int          phase_m;
	pixel_byte_t cb_m;
	pixel_byte_t y1_m;
	pixel_byte_t cr_m;

	// black, studio limits, neutral, top of range
	pixel_byte_t extremes [extreme_count] = '{8'd0, 8'd16, 8'd128, 8'd240, 8'd255};

	color_classifier color_classifier_inst (
		.clk_llc       (clk_llc),
		.resetx        (resetx),
		.sample_active (sample_active),
		.video_byte    (video_byte),
		.class_valid   (class_valid),
		.class_word    (class_word)
	);

	initial
	begin
		clk_llc = 1'b0;
		forever #(clk_period / 2) clk_llc = ~clk_llc;
	end

	// ------------------------------
	// reporting
	// ------------------------------

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want)
		begin
			$display("error: at %0t ns %s is %0h, expected %0h", $time, name, got, want);
			abort_run("stopping at the first mismatch");
		end
	endtask

	// stimulus plus drain, with margin
	initial
	begin
		#((total_cycles + 100) * clk_period);
		abort_run("watchdog expired before the test sequence finished");
	end

	// ------------------------------
	// model and checker
	// ------------------------------

	task automatic push_pixel(input pixel_byte_t y, input pixel_byte_t cb, input pixel_byte_t cr);
		expected_t entry;
		entry.word  = expected_word(y, cb, cr);
		entry.cycle = cyc;
		expected_q.push_back(entry);
	endtask

	// reads the values the DUT samples on this same edge
	always @(posedge clk_llc)
	begin
		cyc = cyc + 1;
		if (resetx === 1'b1 && class_valid === 1'b1)
		begin
			if (expected_q.size() == 0)
				abort_run($sformatf("class_valid at %0t ns with no pixel pending", $time));
			head = expected_q.pop_front();
			check_value("class_word", {16'd0, class_word}, {16'd0, head.word});
			check_value("class_valid latency", cyc - head.cycle, pipe_latency);
		end
		else if (resetx === 1'b1 && class_valid !== 1'b0)
			abort_run("class_valid is unknown after reset");

		// Cb, Y1, Cr, Y2, back to Cb whenever the line write drops
		if (resetx !== 1'b1 || sample_active !== 1'b1)
			phase_m = 0;
		else
		begin
			case (phase_m)
				0: cb_m = video_byte;
				1: y1_m = video_byte;
				2:
				begin
					cr_m = video_byte;
					push_pixel(y1_m, cb_m, video_byte);
				end
				default: push_pixel(video_byte, cb_m, cr_m);
			endcase
			phase_m = (phase_m + 1) % 4;
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------

	task automatic send_byte(input logic active, input pixel_byte_t value);
		@(posedge clk_llc);
		sample_active <= active;
		video_byte    <= value;
	endtask

	task automatic send_group(input pixel_byte_t cb, input pixel_byte_t y1,
		input pixel_byte_t cr, input pixel_byte_t y2);
		send_byte(1'b1, cb);
		send_byte(1'b1, y1);
		send_byte(1'b1, cr);
		send_byte(1'b1, y2);
	endtask

	task automatic pause_stream(input int cycles);
		repeat (cycles) send_byte(1'b0, 8'd0);
	endtask

	// long back to back run, many pixels in flight
	task automatic random_stream();
		int r;
		repeat (random_bytes)
		begin
			r = $random(seed);
			send_byte(1'b1, r[7:0]);
		end
	endtask

	// about one cycle in four idle, cuts groups anywhere
	task automatic toggled_stream();
		int r;
		repeat (toggled_bytes)
		begin
			r = $random(seed);
			send_byte(r[9:8] != 2'b00, r[7:0]);
		end
	endtask

	// darkest and brightest luma with every chroma corner
	task automatic extreme_groups();
		for (int i = 0; i < extreme_count; i++)
			for (int j = 0; j < extreme_count; j++)
				send_group(extremes[i], 8'd16, extremes[j], 8'd235);
	endtask

	// chroma grid, dense enough to land on each hue window edge
	task automatic hue_sweep();
		int cbi;
		int cri;
		for (int i = 0; i < sweep_steps; i++)
			for (int j = 0; j < sweep_steps; j++)
			begin
				cbi = i * 8 + 4;
				cri = j * 8 + 4;
				send_group(cbi[7:0], 8'd110, cri[7:0], 8'd180);
			end
	endtask

	initial
	begin
		seed          = 32'hbc9;
		resetx        = 1'b0;
		sample_active = 1'b0;
		video_byte    = 8'd0;
		cyc           = 0;
		phase_m       = 0;
		cb_m          = 8'd0;
		y1_m          = 8'd0;
		cr_m          = 8'd0;
		repeat (reset_cycles) @(posedge clk_llc);
		resetx <= 1'b1;

		pause_stream(gap_cycles);
		random_stream();
		pause_stream(gap_cycles);
		toggled_stream();
		pause_stream(gap_cycles);
		extreme_groups();
		pause_stream(gap_cycles);
		hue_sweep();
		pause_stream(drain_cycles);

		if (expected_q.size() != 0)
			abort_run($sformatf("%0d pixels never reached the output", expected_q.size()));
		else
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

// ==== filelist.f ====
+incdir+tests
design/vision_pkg.sv
design/ycc_decode.sv
design/rgb_execute.sv
design/hsv_execute.sv
design/color_result.sv
design/color_classifier.sv
tests/color_classifier_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the colour classifier testbench with Verilator and run it
cd "$(dirname "$0")" \
	&& verilator --binary --timing -Wno-fatal -f filelist.f \
		--top-module color_classifier_tb -o color_classifier_sim \
	&& ./obj_dir/color_classifier_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
	&& echo "run_sim: pass" \
	|| { echo "run_sim: fail"; exit 1; }
